//--- mult_buffer.f
src/mult_pkg.sv
src/mem_port_if.sv
src/partial_product_multiplier.sv
src/product_writer.sv
src/block_reader.sv
src/mem_arbiter.sv
src/result_ram.sv
src/mult_buffer.sv
bench/clock_gen.sv
bench/tb_mult_buffer.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mult_buffer
FILELIST  = mult_buffer.f
OBJ_DIR   = obj_dir
PASS_MSG  = SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"

# pass only if the run printed the pass line
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_mult_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mult_buffer;
    import mult_pkg::*;

    localparam int unsigned RANDOM_SEED = 32'he757;
    localparam int NUM_BLOCKS = 8;
    localparam int RESET_CYCLES = 8;
    localparam int CLK_PERIOD_NS = 8;
    // watchdog budget per output word
    localparam int CYCLES_PER_WORD = 4;
    localparam int TIMEOUT_CYCLES = NUM_BLOCKS * DEPTH * CYCLES_PER_WORD + RESET_CYCLES;

    logic                     clk;
    logic                     rst;
    logic                     op_valid;
    logic [OPERAND_WIDTH-1:0] op_a;
    logic [OPERAND_WIDTH-1:0] op_b;
    logic                     op_ready;
    logic                     read_start;
    logic                     block_ready;
    logic                     out_valid;
    logic [PRODUCT_WIDTH-1:0] out_data;

    // reference model state
    logic [PRODUCT_WIDTH-1:0] expected_q [$];
    int                       accepted_cnt;
    int                       shown_cnt;
    // products landed in memory, by the latency rule
    int                       written_cnt;
    // accepts of the last MULT_LATENCY edges, newest in bit 0
    logic [MULT_LATENCY-1:0]  accept_hist;
    // words still due from the open block
    int                       words_owed;
    int                       blocks_done;
    logic                     model_op_ready;
    logic                     model_block_ready;

    clock_gen clk_gen0 (
        .clk (clk)
    );

    mult_buffer dut0 (
        .clk         (clk),
        .rst         (rst),
        .op_valid    (op_valid),
        .op_a        (op_a),
        .op_b        (op_b),
        .op_ready    (op_ready),
        .read_start  (read_start),
        .block_ready (block_ready),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

    // ==================================================================
    // failure reporting
    // ==================================================================

    task automatic stop_failed();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s: expected %h, actual %h", test_name, expected, actual);
            stop_failed();
        end
    endtask

    // ==================================================================
    // per-cycle sampling and checks, at the falling edge
    // ==================================================================

    task automatic check_outputs();
        logic [PRODUCT_WIDTH-1:0] expected_word;
        int                       in_flight;
        int                       stored;
        if (out_valid) begin
            assert (words_owed > 0) else begin
                $display("out_valid seen with no accepted read start open");
                stop_failed();
            end
            expected_word = expected_q.pop_front();
            check_value("product order", expected_word, out_data);
            words_owed = words_owed - 1;
            shown_cnt  = shown_cnt + 1;
            if (words_owed == 0) begin
                blocks_done = blocks_done + 1;
            end
        end
        // word on out_valid now was granted last cycle, its slot is already free
        in_flight         = accepted_cnt - shown_cnt;
        stored            = written_cnt - shown_cnt;
        model_op_ready    = (in_flight != DEPTH);
        model_block_ready = (stored == DEPTH);
        check_value("op_ready back-pressure", 32'(model_op_ready), 32'(op_ready));
        check_value("block_ready", 32'(model_block_ready), 32'(block_ready));
    endtask

    // ==================================================================
    // random stimulus for the next rising edge
    // ==================================================================

    task automatic drive_inputs();
        logic       take;
        logic [1:0] corner;
        op_valid = ($urandom_range(99) < 70);
        if (accepted_cnt % 8 == 7) begin
            // extreme operands, zero and all ones
            corner = 2'($urandom_range(3));
            op_a   = corner[0] ? 16'hffff : 16'h0000;
            op_b   = corner[1] ? 16'hffff : 16'h0000;
        end else begin
            op_a = 16'($urandom);
            op_b = 16'($urandom);
        end
        // also fires while no block waits or one is streaming
        read_start = ($urandom_range(7) == 0);
        if (read_start && model_block_ready && words_owed == 0) begin
            words_owed = DEPTH;
        end
        take = op_valid && model_op_ready;
        if (take) begin
            expected_q.push_back(PRODUCT_WIDTH'(op_a) * PRODUCT_WIDTH'(op_b));
            accepted_cnt = accepted_cnt + 1;
        end
        // oldest accept reaches memory at this edge
        written_cnt = written_cnt + int'(accept_hist[MULT_LATENCY-1]);
        accept_hist = {accept_hist[MULT_LATENCY-2:0], take};
    endtask

    // ==================================================================
    // main sequence
    // ==================================================================

    initial begin
        void'($urandom(RANDOM_SEED));
        rst               = 1'b1;
        op_valid          = 1'b0;
        op_a              = '0;
        op_b              = '0;
        read_start        = 1'b0;
        accepted_cnt      = 0;
        shown_cnt         = 0;
        written_cnt       = 0;
        accept_hist       = '0;
        words_owed        = 0;
        blocks_done       = 0;
        model_op_ready    = 1'b1;
        model_block_ready = 1'b0;
        // reset held over RESET_CYCLES rising edges
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        // state left by the last reset edge
        check_value("reset op_ready", 32'd1, 32'(op_ready));
        check_value("reset block_ready", 32'd0, 32'(block_ready));
        check_value("reset out_valid", 32'd0, 32'(out_valid));
        rst = 1'b0;
        while (blocks_done < NUM_BLOCKS) begin
            @(negedge clk);
            check_outputs();
            drive_inputs();
        end
        $display("read %0d blocks, %0d pairs accepted", blocks_done, accepted_cnt);
        $display("SIMULATION PASSED");
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD_NS);
        $display("watchdog expired after %0d cycles, blocks read %0d of %0d",
                 TIMEOUT_CYCLES, blocks_done, NUM_BLOCKS);
        stop_failed();
    end

endmodule

`default_nettype wire

//--- bench/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clk
);
    // 8 ns period
    localparam int HALF_PERIOD_NS = 4;

    initial begin
        clk = 1'b0;
    end

    always begin
        #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- src/mult_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module mult_buffer (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                op_valid,
    input  wire  [mult_pkg::OPERAND_WIDTH-1:0] op_a,
    input  wire  [mult_pkg::OPERAND_WIDTH-1:0] op_b,
    output logic                               op_ready,
    input  wire                                read_start,
    output logic                               block_ready,
    output logic                               out_valid,
    output logic [mult_pkg::PRODUCT_WIDTH-1:0] out_data
);
    import mult_pkg::*;

    // ==================================================================
    // internal wiring
    // ==================================================================

    logic                     op_fire;
    logic                     prod_valid;
    logic [PRODUCT_WIDTH-1:0] prod_data;
    logic                     slot_freed;

    mem_port_if wr_port ();
    mem_port_if rd_port ();
    mem_port_if ram_port ();

    // only accepted pairs enter the pipeline
    assign op_fire = op_valid && op_ready;

    partial_product_multiplier mult0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (op_fire),
        .a         (op_a),
        .b         (op_b),
        .out_valid (prod_valid),
        .product   (prod_data)
    );

    product_writer writer0 (
        .clk         (clk),
        .rst         (rst),
        .op_valid    (op_valid),
        .op_ready    (op_ready),
        .prod_valid  (prod_valid),
        .prod_data   (prod_data),
        .slot_freed  (slot_freed),
        .block_ready (block_ready),
        .mem         (wr_port.requester)
    );

    block_reader reader0 (
        .clk         (clk),
        .rst         (rst),
        .read_start  (read_start),
        .block_ready (block_ready),
        .slot_freed  (slot_freed),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .mem         (rd_port.requester)
    );

    // writer has priority over reader
    mem_arbiter arb0 (
        .wr  (wr_port.arbiter),
        .rd  (rd_port.arbiter),
        .ram (ram_port.requester)
    );

    result_ram ram0 (
        .clk (clk),
        .mem (ram_port.memory)
    );

endmodule

`default_nettype wire

//--- src/result_ram.sv
`timescale 1ns/1ps
`default_nettype none

module result_ram (
    input wire         clk,
    mem_port_if.memory mem
);
    import mult_pkg::*;

    // product storage, circular use by writer and reader
    logic [PRODUCT_WIDTH-1:0] store [DEPTH];

    // single port, one access per cycle
    always_ff @(posedge clk) begin
        if (mem.req) begin
            if (mem.we) begin
                store[mem.addr] <= mem.wdata;
            end else begin
                // one-cycle read, held until the next read
                mem.rdata <= store[mem.addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- src/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    mem_port_if.arbiter   wr,
    mem_port_if.arbiter   rd,
    mem_port_if.requester ram
);

    // ==================================================================
    // grants
    // ==================================================================

    // multiplier pipeline cannot stall, writer always wins
    assign wr.grant = wr.req;
    // reader waits out any collision
    assign rd.grant = rd.req && !wr.req;

    // ==================================================================
    // request steering
    // ==================================================================

    assign ram.req = wr.req || rd.req;

    always_comb begin
        if (wr.req) begin
            ram.we    = wr.we;
            ram.addr  = wr.addr;
            ram.wdata = wr.wdata;
        end else begin
            // reader or nobody
            ram.we    = rd.we;
            ram.addr  = rd.addr;
            ram.wdata = rd.wdata;
        end
    end

    // ==================================================================
    // read data
    // ==================================================================

    // shared bus back to both sides
    // ram only updates rdata on a read, so a writer grant
    // right after a reader grant leaves the word intact
    assign wr.rdata = ram.rdata;
    assign rd.rdata = ram.rdata;

endmodule

`default_nettype wire

//--- src/block_reader.sv
`timescale 1ns/1ps
`default_nettype none

module block_reader (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                read_start,
    input  wire                                block_ready,
    output logic                               slot_freed,
    output logic                               out_valid,
    output logic [mult_pkg::PRODUCT_WIDTH-1:0] out_data,
    mem_port_if.requester                      mem
);
    import mult_pkg::*;

    rd_state_t              state;
    logic [ADDR_WIDTH-1:0]  rd_ptr;
    // granted reads in this block
    logic [COUNT_WIDTH-1:0] rd_cnt;
    logic                   granted;

    // ask every cycle while a block is open
    assign mem.req   = (state == RD_ACTIVE);
    assign mem.we    = 1'b0;
    // held until granted
    assign mem.addr  = rd_ptr;
    assign mem.wdata = '0;

    assign granted    = mem.req && mem.grant;
    // slot can take a new product right away
    assign slot_freed = granted;
    // ram registers rdata, lines up with out_valid
    assign out_data   = mem.rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= RD_IDLE;
            rd_ptr    <= '0;
            rd_cnt    <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= granted;
            if (granted) begin
                rd_ptr <= rd_ptr + ADDR_WIDTH'(1);
            end
            case (state)
                RD_IDLE: begin
                    // start dropped unless a full block waits
                    if (read_start && block_ready) begin
                        state  <= RD_ACTIVE;
                        rd_cnt <= '0;
                    end
                end
                RD_ACTIVE: begin
                    if (granted) begin
                        rd_cnt <= rd_cnt + COUNT_WIDTH'(1);
                        // last word of the block
                        if (rd_cnt == COUNT_WIDTH'(DEPTH - 1)) begin
                            state <= RD_IDLE;
                        end
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/product_writer.sv
`timescale 1ns/1ps
`default_nettype none

module product_writer (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                op_valid,
    output logic                               op_ready,
    input  wire                                prod_valid,
    input  wire  [mult_pkg::PRODUCT_WIDTH-1:0] prod_data,
    input  wire                                slot_freed,
    output logic                               block_ready,
    mem_port_if.requester                      mem
);
    import mult_pkg::*;

    // in flight plus stored unread
    logic [COUNT_WIDTH-1:0] reserved_cnt;
    // stored unread only
    logic [COUNT_WIDTH-1:0] stored_cnt;
    logic [ADDR_WIDTH-1:0]  wr_ptr;
    logic                   accept;
    logic                   stored;

    assign accept = op_valid && op_ready;
    // a granted write stores the product at this edge
    assign stored = mem.req && mem.grant;

    // every product is written the cycle it arrives
    assign mem.req   = prod_valid;
    assign mem.we    = 1'b1;
    assign mem.addr  = wr_ptr;
    assign mem.wdata = prod_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            reserved_cnt <= '0;
            stored_cnt   <= '0;
            wr_ptr       <= '0;
        end else begin
            reserved_cnt <= reserved_cnt + COUNT_WIDTH'(accept) - COUNT_WIDTH'(slot_freed);
            stored_cnt   <= stored_cnt + COUNT_WIDTH'(stored) - COUNT_WIDTH'(slot_freed);
            // wraps at DEPTH
            if (stored) begin
                wr_ptr <= wr_ptr + ADDR_WIDTH'(1);
            end
        end
    end

    // back-pressure only once every slot is spoken for
    assign op_ready    = (reserved_cnt != COUNT_WIDTH'(DEPTH));
    assign block_ready = (stored_cnt == COUNT_WIDTH'(DEPTH));

endmodule

`default_nettype wire

//--- src/partial_product_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module partial_product_multiplier (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                in_valid,
    input  wire  [mult_pkg::OPERAND_WIDTH-1:0] a,
    input  wire  [mult_pkg::OPERAND_WIDTH-1:0] b,
    output logic                               out_valid,
    output logic [mult_pkg::PRODUCT_WIDTH-1:0] product
);
    import mult_pkg::*;

    // operand copies per stage
    logic [OPERAND_WIDTH-1:0] a_s1, b_s1;
    logic [OPERAND_WIDTH-1:0] a_s2, b_s2;
    // 4x4 nibble products, 8 bits each
    logic [7:0]               pp_s2 [NIBBLES/2][NIBBLES];
    logic [7:0]               pp_s3 [NIBBLES][NIBBLES];
    // shifted into product position
    logic [PRODUCT_WIDTH-1:0] spp_s4 [NIBBLES*NIBBLES];
    // one sum per row of a
    logic [PRODUCT_WIDTH-1:0] row_s5 [NIBBLES];
    // valid bit follows the data, one bit per stage
    logic [MULT_LATENCY-1:0]  vld;

    // ==================================================================
    // stages 1 to 3: operands in, nibble products
    // ==================================================================

    always_ff @(posedge clk) begin
        a_s1 <= a;
        b_s1 <= b;
        a_s2 <= a_s1;
        b_s2 <= b_s1;
        // low rows of a first
        for (int i = 0; i < NIBBLES/2; i++) begin
            for (int j = 0; j < NIBBLES; j++) begin
                pp_s2[i][j] <= 8'(a_s1[4*i +: 4]) * 8'(b_s1[4*j +: 4]);
            end
        end
        // forward low rows so all sixteen line up
        for (int i = 0; i < NIBBLES/2; i++) begin
            for (int j = 0; j < NIBBLES; j++) begin
                pp_s3[i][j] <= pp_s2[i][j];
            end
        end
        // then high rows
        for (int i = NIBBLES/2; i < NIBBLES; i++) begin
            for (int j = 0; j < NIBBLES; j++) begin
                pp_s3[i][j] <= 8'(a_s2[4*i +: 4]) * 8'(b_s2[4*j +: 4]);
            end
        end
    end

    // ==================================================================
    // stages 4 to 6: align and sum
    // ==================================================================

    always_ff @(posedge clk) begin
        // weight of a_i*b_j is 2^(4*(i+j))
        for (int i = 0; i < NIBBLES; i++) begin
            for (int j = 0; j < NIBBLES; j++) begin
                spp_s4[NIBBLES*i + j] <= PRODUCT_WIDTH'(pp_s3[i][j]) << (4 * (i + j));
            end
        end
        // tree level one, sixteen down to four
        for (int i = 0; i < NIBBLES; i++) begin
            row_s5[i] <= spp_s4[NIBBLES*i] + spp_s4[NIBBLES*i + 1]
                       + spp_s4[NIBBLES*i + 2] + spp_s4[NIBBLES*i + 3];
        end
        // level two, final sum
        product <= row_s5[0] + row_s5[1] + row_s5[2] + row_s5[3];
    end

    // valid shift register
    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= '0;
        end else begin
            vld <= {vld[MULT_LATENCY-2:0], in_valid};
        end
    end

    assign out_valid = vld[MULT_LATENCY-1];

endmodule

`default_nettype wire

//--- src/mem_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if;
    import mult_pkg::*;

    // request side
    logic                     req;
    logic                     we;
    logic [ADDR_WIDTH-1:0]    addr;
    logic [PRODUCT_WIDTH-1:0] wdata;

    // answer side
    // grant high with req means served this cycle
    logic                     grant;
    // read data one cycle after a granted read
    logic [PRODUCT_WIDTH-1:0] rdata;

    // a block asking for the memory
    modport requester (
        output req, we, addr, wdata,
        input  grant, rdata
    );

    // arbiter side of a requester
    modport arbiter (
        input  req, we, addr, wdata,
        output grant, rdata
    );

    // single-port memory, always serves
    modport memory (
        input  req, we, addr, wdata,
        output rdata
    );

endinterface

`default_nettype wire

//--- src/mult_pkg.sv
`default_nettype none

package mult_pkg;

    // ==================================================================
    // datapath sizes
    // ==================================================================

    localparam int OPERAND_WIDTH = 16;
    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

    // nibbles per operand for the partial products
    localparam int NIBBLES = OPERAND_WIDTH / 4;

    // ==================================================================
    // result buffer
    // ==================================================================

    // one block is the whole memory
    localparam int DEPTH = 64;
    localparam int ADDR_WIDTH = $clog2(DEPTH);
    // one extra bit so a full count of DEPTH fits
    localparam int COUNT_WIDTH = ADDR_WIDTH + 1;

    // operand accept to product at the writer
    localparam int MULT_LATENCY = 6;

    // block reader FSM
    typedef enum logic {
        RD_IDLE,
        RD_ACTIVE
    } rd_state_t;

endpackage

`default_nettype wire
